// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// First fetch address after reset
`define CPU_RESET_PC 32'h1c00_0000

`define CPU_NUM_REGS 32

// Instruction memory size in 32-bit words
`define CPU_IMEM_WORDS 1024

`endif

// File: hw/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        alu_op_e     alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] store_data;
        logic        mem_en;
        logic        mem_we;
        logic        res_from_mem;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic [31:0] result;
        logic        res_from_mem;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic [31:0] value;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // One later stage as seen by the hazard unit
    typedef struct packed {
        logic        valid;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        is_load;
    } fwd_src_t;

endpackage

// File: hw/if_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module if_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ds_allow_in,
    input  br_bus_t     br,
    input  logic [31:0] inst_sram_rdata,
    output logic        fs_to_ds_valid,
    output fs_to_ds_t   fs_to_ds,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr
);
    logic [31:0] fs_pc;
    logic        fs_valid;
    logic        fs_allow_in;
    logic [31:0] next_pc;
    logic [31:0] inst_buf;
    logic        inst_buf_valid;
    logic [31:0] fs_inst;

    // Request for the next PC goes out while the current word returns
    assign fs_allow_in    = ~fs_valid | ds_allow_in;
    assign next_pc        = br.taken ? br.target : fs_pc + 32'd4;
    assign inst_sram_en   = fs_allow_in;
    assign inst_sram_addr = next_pc;

    // Returned word is kept while decode holds
    assign fs_inst = inst_buf_valid ? inst_buf : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
            fs_pc    <= `CPU_RESET_PC - 32'd4;
        end else if (fs_allow_in) begin
            fs_valid <= 1'b1;
            fs_pc    <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fs_allow_in)
            inst_buf_valid <= 1'b0;
        else
            inst_buf_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!fs_allow_in && !inst_buf_valid)
            inst_buf <= inst_sram_rdata;
    end

    // Word behind a taken branch is dropped
    always_ff @(posedge clk) begin
        if (rst)
            fs_to_ds_valid <= 1'b0;
        else if (ds_allow_in)
            fs_to_ds_valid <= fs_valid & ~br.taken;
    end

    always_ff @(posedge clk) begin
        if (ds_allow_in && fs_valid)
            fs_to_ds <= '{pc: fs_pc, inst: fs_inst};
    end

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fs_to_ds_valid,
    input  fs_to_ds_t   fs_to_ds,
    input  logic        es_allow_in,
    input  logic [31:0] rf_rdata1,
    input  logic [31:0] rf_rdata2,
    input  logic        pause,
    input  logic        occur1,
    input  logic        occur2,
    input  logic [31:0] forward1,
    input  logic [31:0] forward2,
    output logic        ds_allow_in,
    output logic [4:0]  rf_raddr1,
    output logic [4:0]  rf_raddr2,
    output br_bus_t     br,
    output logic        ds_to_es_valid,
    output ds_to_es_t   ds_to_es
);
    logic [31:0] inst;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic        inst_ld_w, inst_st_w, inst_jirl, inst_b;
    logic        inst_bl, inst_beq, inst_bne, inst_lu12i_w;
    logic        reg_alu;
    logic        shift_imm;
    logic        link;
    logic        gr_we;
    logic        src2_is_imm;
    alu_op_e     alu_op;
    logic [31:0] imm_ui5, imm_si12, imm_si20, imm_si16, imm_si26;
    logic [31:0] imm;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic        rj_eq_rd;
    logic        ds_ready_go;
    logic        ds_go;
    ds_to_es_t   ds_next;

    assign inst = fs_to_ds.inst;
    assign pc   = fs_to_ds.pc;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign inst_add_w   = inst[31:15] == 17'h00020;
    assign inst_sub_w   = inst[31:15] == 17'h00022;
    assign inst_slt     = inst[31:15] == 17'h00024;
    assign inst_sltu    = inst[31:15] == 17'h00025;
    assign inst_nor     = inst[31:15] == 17'h00028;
    assign inst_and     = inst[31:15] == 17'h00029;
    assign inst_or      = inst[31:15] == 17'h0002a;
    assign inst_xor     = inst[31:15] == 17'h0002b;
    assign inst_slli_w  = inst[31:15] == 17'h00081;
    assign inst_srli_w  = inst[31:15] == 17'h00089;
    assign inst_srai_w  = inst[31:15] == 17'h00091;
    assign inst_addi_w  = inst[31:22] == 10'h00a;
    assign inst_ld_w    = inst[31:22] == 10'h0a2;
    assign inst_st_w    = inst[31:22] == 10'h0a6;
    assign inst_jirl    = inst[31:26] == 6'h13;
    assign inst_b       = inst[31:26] == 6'h14;
    assign inst_bl      = inst[31:26] == 6'h15;
    assign inst_beq     = inst[31:26] == 6'h16;
    assign inst_bne     = inst[31:26] == 6'h17;
    assign inst_lu12i_w = inst[31:25] == 7'h0a;

    assign reg_alu   = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                     | inst_nor | inst_and | inst_or | inst_xor;
    assign shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    assign link      = inst_jirl | inst_bl;
    assign gr_we     = reg_alu | shift_imm | inst_addi_w | inst_lu12i_w | inst_ld_w | link;

    always_comb begin
        case (1'b1)
            inst_sub_w:   alu_op = ALU_SUB;
            inst_slt:     alu_op = ALU_SLT;
            inst_sltu:    alu_op = ALU_SLTU;
            inst_and:     alu_op = ALU_AND;
            inst_nor:     alu_op = ALU_NOR;
            inst_or:      alu_op = ALU_OR;
            inst_xor:     alu_op = ALU_XOR;
            inst_slli_w:  alu_op = ALU_SLL;
            inst_srli_w:  alu_op = ALU_SRL;
            inst_srai_w:  alu_op = ALU_SRA;
            inst_lu12i_w: alu_op = ALU_LUI;
            default:      alu_op = ALU_ADD;
        endcase
    end

    assign imm_ui5  = {27'b0, rk};
    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_si20 = {inst[24:5], 12'b0};
    assign imm_si16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign imm_si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    // Link instructions compute pc + 4 in the ALU
    assign src2_is_imm = shift_imm | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w | link;
    assign imm = link                                ? 32'd4    :
                 inst_lu12i_w                        ? imm_si20 :
                 (inst_addi_w | inst_ld_w | inst_st_w) ? imm_si12 :
                                                       imm_ui5;

    // Unused sources read r0 so they never match a hazard
    assign rf_raddr1 = (inst_b | inst_bl | inst_lu12i_w) ? 5'd0 : rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd :
                       reg_alu                           ? rk : 5'd0;

    assign rj_value  = occur1 ? forward1 : rf_rdata1;
    assign rkd_value = occur2 ? forward2 : rf_rdata2;

    assign ds_ready_go = ~pause;
    assign ds_allow_in = ~fs_to_ds_valid | (ds_ready_go & es_allow_in);
    assign ds_go       = fs_to_ds_valid & ds_ready_go & es_allow_in;

    assign rj_eq_rd  = rj_value == rkd_value;
    assign br.taken  = ds_go & (inst_beq & rj_eq_rd | inst_bne & ~rj_eq_rd
                              | inst_jirl | inst_b | inst_bl);
    assign br.target = inst_jirl        ? rj_value + imm_si16 :
                       (inst_b | inst_bl) ? pc + imm_si26 : pc + imm_si16;

    assign ds_next = '{
        alu_op:       alu_op,
        src1:         link ? pc : rj_value,
        src2:         src2_is_imm ? imm : rkd_value,
        store_data:   rkd_value,
        mem_en:       inst_ld_w | inst_st_w,
        mem_we:       inst_st_w,
        res_from_mem: inst_ld_w,
        rf_we:        gr_we,
        dest:         inst_bl ? 5'd1 : rd,
        pc:           pc
    };

    // Pause leaves a bubble in execute
    always_ff @(posedge clk) begin
        if (rst)
            ds_to_es_valid <= 1'b0;
        else if (es_allow_in)
            ds_to_es_valid <= fs_to_ds_valid & ds_ready_go;
    end

    always_ff @(posedge clk) begin
        if (ds_go)
            ds_to_es <= ds_next;
    end

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ds_to_es_valid,
    input  ds_to_es_t   ds_to_es,
    input  logic        ms_allow_in,
    output logic        es_allow_in,
    output fwd_src_t    es_fwd,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output logic        es_to_ms_valid,
    output es_to_ms_t   es_to_ms
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] alu_result;
    logic        es_go;

    assign a = ds_to_es.src1;
    assign b = ds_to_es.src2;

    always_comb begin
        case (ds_to_es.alu_op)
            ALU_SUB:  alu_result = a - b;
            ALU_SLT:  alu_result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: alu_result = {31'b0, a < b};
            ALU_AND:  alu_result = a & b;
            ALU_NOR:  alu_result = ~(a | b);
            ALU_OR:   alu_result = a | b;
            ALU_XOR:  alu_result = a ^ b;
            ALU_SLL:  alu_result = a << b[4:0];
            ALU_SRL:  alu_result = a >> b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(a) >>> b[4:0]);
            ALU_LUI:  alu_result = b;
            default:  alu_result = a + b;
        endcase
    end

    assign es_allow_in = ~ds_to_es_valid | ms_allow_in;
    assign es_go       = ds_to_es_valid & ms_allow_in;

    // Address is the ALU sum, full word stores only
    assign data_sram_en    = es_go & ds_to_es.mem_en;
    assign data_sram_we    = {4{es_go & ds_to_es.mem_we}};
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = ds_to_es.store_data;

    // Load data is not ready until memory
    assign es_fwd = '{
        valid:   ds_to_es_valid,
        rf_we:   ds_to_es.rf_we,
        dest:    ds_to_es.dest,
        value:   alu_result,
        is_load: ds_to_es.res_from_mem
    };

    always_ff @(posedge clk) begin
        if (rst)
            es_to_ms_valid <= 1'b0;
        else if (ms_allow_in)
            es_to_ms_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk) begin
        if (es_go)
            es_to_ms <= '{
                result:       alu_result,
                res_from_mem: ds_to_es.res_from_mem,
                rf_we:        ds_to_es.rf_we,
                dest:         ds_to_es.dest,
                pc:           ds_to_es.pc
            };
    end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        es_to_ms_valid,
    input  es_to_ms_t   es_to_ms,
    input  logic [31:0] data_sram_rdata,
    output logic        ms_allow_in,
    output fwd_src_t    ms_fwd,
    output logic        ms_to_ws_valid,
    output ms_to_ws_t   ms_to_ws
);
    logic [31:0] final_value;

    // Writeback never stalls
    assign ms_allow_in = 1'b1;

    assign final_value = es_to_ms.res_from_mem ? data_sram_rdata : es_to_ms.result;

    assign ms_fwd = '{
        valid:   es_to_ms_valid,
        rf_we:   es_to_ms.rf_we,
        dest:    es_to_ms.dest,
        value:   final_value,
        is_load: 1'b0
    };

    always_ff @(posedge clk) begin
        if (rst)
            ms_to_ws_valid <= 1'b0;
        else
            ms_to_ws_valid <= es_to_ms_valid;
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid)
            ms_to_ws <= '{
                value: final_value,
                rf_we: es_to_ms.rf_we,
                dest:  es_to_ms.dest,
                pc:    es_to_ms.pc
            };
    end

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module wb_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ms_to_ws_valid,
    input  ms_to_ws_t   ms_to_ws,
    input  logic [4:0]  rf_raddr1,
    input  logic [4:0]  rf_raddr2,
    output logic [31:0] rf_rdata1,
    output logic [31:0] rf_rdata2,
    output fwd_src_t    ws_fwd,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    logic [31:0] rf [`CPU_NUM_REGS];
    logic        wb_we;

    // r0 is never written
    assign wb_we = ms_to_ws_valid & ms_to_ws.rf_we & (ms_to_ws.dest != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst && wb_we)
            rf[ms_to_ws.dest] <= ms_to_ws.value;
    end

    assign rf_rdata1 = (rf_raddr1 == 5'd0) ? 32'd0 : rf[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == 5'd0) ? 32'd0 : rf[rf_raddr2];

    // Covers the read of a register written this cycle
    assign ws_fwd = '{
        valid:   ms_to_ws_valid,
        rf_we:   ms_to_ws.rf_we,
        dest:    ms_to_ws.dest,
        value:   ms_to_ws.value,
        is_load: 1'b0
    };

    assign debug_wb_pc       = ms_to_ws.pc;
    assign debug_wb_rf_we    = wb_we;
    assign debug_wb_rf_wnum  = ms_to_ws.dest;
    assign debug_wb_rf_wdata = ms_to_ws.value;

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  logic [4:0]  rf_raddr1,
    input  logic [4:0]  rf_raddr2,
    input  fwd_src_t    es_fwd,
    input  fwd_src_t    ms_fwd,
    input  fwd_src_t    ws_fwd,
    output logic        occur1,
    output logic        occur2,
    output logic [31:0] forward1,
    output logic [31:0] forward2,
    output logic        pause
);
    function automatic logic hit(input logic [4:0] addr, input fwd_src_t src);
        return src.valid && src.rf_we && (src.dest == addr) && (addr != 5'd0);
    endfunction

    // Youngest stage first
    assign occur1   = hit(rf_raddr1, es_fwd) | hit(rf_raddr1, ms_fwd) | hit(rf_raddr1, ws_fwd);
    assign forward1 = hit(rf_raddr1, es_fwd) ? es_fwd.value :
                      hit(rf_raddr1, ms_fwd) ? ms_fwd.value : ws_fwd.value;

    assign occur2   = hit(rf_raddr2, es_fwd) | hit(rf_raddr2, ms_fwd) | hit(rf_raddr2, ws_fwd);
    assign forward2 = hit(rf_raddr2, es_fwd) ? es_fwd.value :
                      hit(rf_raddr2, ms_fwd) ? ms_fwd.value : ws_fwd.value;

    // Load result only exists once it reaches memory
    assign pause = es_fwd.is_load & (hit(rf_raddr1, es_fwd) | hit(rf_raddr2, es_fwd));

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    logic        ds_allow_in;
    logic        es_allow_in;
    logic        ms_allow_in;
    br_bus_t     br;
    logic        fs_to_ds_valid;
    fs_to_ds_t   fs_to_ds;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms;
    logic        ms_to_ws_valid;
    ms_to_ws_t   ms_to_ws;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    fwd_src_t    es_fwd;
    fwd_src_t    ms_fwd;
    fwd_src_t    ws_fwd;
    logic        occur1;
    logic        occur2;
    logic [31:0] forward1;
    logic [31:0] forward2;
    logic        pause;

    if_stage    u_if_stage    (.*);
    id_stage    u_id_stage    (.*);
    ex_stage    u_ex_stage    (.*);
    mem_stage   u_mem_stage   (.*);
    wb_stage    u_wb_stage    (.*);
    hazard_unit u_hazard_unit (.*);

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 5;
    localparam int PROG_WORDS = 128;
    localparam logic [31:0] HALT = 32'h5000_0000;
    localparam logic [16:0] R3_OPS [8] = '{17'h20, 17'h22, 17'h24, 17'h25,
                                          17'h28, 17'h29, 17'h2a, 17'h2b};
    localparam logic [16:0] SHIFT_OPS [3] = '{17'h81, 17'h89, 17'h91};

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [`CPU_IMEM_WORDS];
    logic [31:0] dmem [256];
    logic [31:0] exp_mem [256];
    logic [31:0] lfsr = 32'd26;
    int          n_words;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    bit          first_seen;
    int          errors;
    int          pass_count;
    int          fail_count;

    // Bus values latched mid-cycle and served at the next edge
    logic        i_en, d_en;
    logic [3:0]  d_we;
    logic [31:0] i_addr, d_addr, d_wdata;

    cpu_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int imem_index(input logic [31:0] addr);
        return ((addr - `CPU_RESET_PC) >> 2) % `CPU_IMEM_WORDS;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h3c5a_96e1 ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [31:0] imm,
                                            input logic [4:0] rj, input logic [4:0] rd);
        return {op, imm[11:0], rj, rd};
    endfunction

    // Offset fields count words
    function automatic logic [31:0] enc_off16(input logic [5:0] op, input logic [31:0] offs,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs[15:0], rj, rd};
    endfunction

    function automatic logic [31:0] enc_b(input logic [5:0] op, input logic [31:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] alu_inst(input logic [4:0] rd, input logic [4:0] rj,
                                             input logic [4:0] rk);
        int          sel;
        logic [31:0] imm;
        sel = rand_bits(4) % 13;
        imm = rand_bits(20);
        if (sel < 8)
            return {R3_OPS[sel], rk, rj, rd};
        if (sel < 11)
            return {SHIFT_OPS[sel - 8], rk, rj, rd};
        if (sel == 11)
            return enc_i12(10'h00a, imm, rj, rd);
        return {7'h0a, imm[19:0], rd};
    endfunction

    function automatic logic [4:0] nonzero_reg();
        return 5'(rand_bits(5) % 31 + 1);
    endfunction

    function automatic logic [4:0] any_reg();
        return 5'(rand_bits(5));
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[n_words] = w;
        n_words++;
    endtask

    task automatic build_program(input int kind);
        logic [4:0]  rd, rj, p1, p2, p3;
        logic [31:0] off, off2;
        int          k;
        n_words = 0;
        for (int i = 0; i < `CPU_IMEM_WORDS; i++)
            imem[i] = HALT;
        for (int i = 0; i < 256; i++)
            dmem[i] = fill_word(i * 4);
        // Every register gets a known value first
        for (int r = 1; r < 32; r++)
            if (r % 2)
                emit({7'h0a, 20'(rand_bits(20)), 5'(r)});
            else
                emit(enc_i12(10'h00a, rand_bits(12), 5'd0, 5'(r)));
        p1 = 5'd1;
        p2 = 5'd2;
        p3 = 5'd3;
        case (kind)
            0: repeat (40) emit(alu_inst(any_reg(), any_reg(), any_reg()));
            1: repeat (40) begin
                rd = nonzero_reg();
                emit(alu_inst(rd, p1, rand_bits(1) ? p2 : p3));
                p3 = p2;
                p2 = p1;
                p1 = rd;
            end
            2: repeat (12) begin
                off  = rand_bits(8) * 4;
                off2 = rand_bits(1) ? off : rand_bits(8) * 4;
                rd   = nonzero_reg();
                emit(enc_i12(10'h0a6, off, 5'd0, any_reg()));
                emit(enc_i12(10'h0a2, off2, 5'd0, rd));
                emit({17'h20, any_reg(), rd, nonzero_reg()});
            end
            3: repeat (10) begin
                emit(alu_inst(any_reg(), any_reg(), any_reg()));
                rj = any_reg();
                rd = rand_bits(1) ? rj : any_reg();
                k  = 2 + rand_bits(1);
                emit(enc_off16(rand_bits(1) ? 6'h16 : 6'h17, k, rj, rd));
                repeat (k - 1) emit(alu_inst(any_reg(), any_reg(), any_reg()));
                emit(enc_b(6'h14, 2));
                emit(alu_inst(any_reg(), any_reg(), any_reg()));
            end
            default: repeat (8) begin
                // bl skips one word, jirl off r1 skips the next
                emit(alu_inst(any_reg(), any_reg(), any_reg()));
                emit(enc_b(6'h15, 2));
                emit(alu_inst(any_reg(), any_reg(), any_reg()));
                emit(enc_off16(6'h13, 3, 5'd1, any_reg()));
                emit(alu_inst(any_reg(), any_reg(), any_reg()));
            end
        endcase
        emit(HALT);
    endtask

    // ISA model of the program, builds the expected writeback trace
    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] pc, w, a, b, v, npc, addr, si12, o16, o26;
        logic [4:0]  rd, sa;
        logic        we;
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        for (int i = 0; i < 32; i++)
            r[i] = 0;
        for (int i = 0; i < 256; i++)
            exp_mem[i] = fill_word(i * 4);
        pc = `CPU_RESET_PC;
        for (int step = 0; step < 1000; step++) begin
            w = imem[imem_index(pc)];
            if (w == HALT)
                break;
            rd   = w[4:0];
            sa   = w[14:10];
            a    = r[w[9:5]];
            b    = r[w[14:10]];
            si12 = {{20{w[21]}}, w[21:10]};
            o16  = {{14{w[25]}}, w[25:10], 2'b00};
            o26  = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            addr = a + si12;
            we   = 1'b1;
            v    = 0;
            npc  = pc + 4;
            case (w[31:15])
                17'h20: v = a + b;
                17'h22: v = a - b;
                17'h24: v = {31'b0, $signed(a) < $signed(b)};
                17'h25: v = {31'b0, a < b};
                17'h28: v = ~(a | b);
                17'h29: v = a & b;
                17'h2a: v = a | b;
                17'h2b: v = a ^ b;
                17'h81: v = a << sa;
                17'h89: v = a >> sa;
                17'h91: v = $signed(a) >>> sa;
                default: begin
                    we = 1'b0;
                    if (w[31:22] == 10'h00a) begin
                        we = 1'b1;
                        v  = addr;
                    end else if (w[31:22] == 10'h0a2) begin
                        we = 1'b1;
                        v  = exp_mem[addr[9:2]];
                    end else if (w[31:22] == 10'h0a6) begin
                        exp_mem[addr[9:2]] = r[rd];
                    end else if (w[31:25] == 7'h0a) begin
                        we = 1'b1;
                        v  = {w[24:5], 12'b0};
                    end else begin
                        case (w[31:26])
                            6'h13: begin
                                we  = 1'b1;
                                v   = pc + 4;
                                npc = a + o16;
                            end
                            6'h14: npc = pc + o26;
                            6'h15: begin
                                we  = 1'b1;
                                v   = pc + 4;
                                rd  = 5'd1;
                                npc = pc + o26;
                            end
                            6'h16: if (a == r[rd]) npc = pc + o16;
                            6'h17: if (a != r[rd]) npc = pc + o16;
                            default: ;
                        endcase
                    end
                end
            endcase
            if (we && rd != 5'd0) begin
                r[rd] = v;
                exp_pc.push_back(pc);
                exp_num.push_back(rd);
                exp_val.push_back(v);
            end
            pc = npc;
        end
    endtask

    always @(negedge clk) begin
        i_en    = inst_sram_en;
        i_addr  = inst_sram_addr;
        d_en    = data_sram_en;
        d_we    = data_sram_we;
        d_addr  = data_sram_addr;
        d_wdata = data_sram_wdata;
    end

    always @(posedge clk) begin
        #1;
        if (i_en === 1'b1)
            inst_sram_rdata = imem[imem_index(i_addr)];
        if (d_en === 1'b1) begin
            if (d_we == 4'hf)
                dmem[d_addr[9:2]] = d_wdata;
            else if (d_we == 4'h0)
                data_sram_rdata = dmem[d_addr[9:2]];
            else begin
                $display("[FAIL] data_sram_we: got %h, expected f", d_we);
                errors++;
            end
        end
    end

    // Writeback trace comparison
    always @(negedge clk) begin
        if (!rst && !first_seen && data_sram_we !== 4'b0) begin
            $display("data_sram_we went high before the first instruction retired");
            errors++;
        end
        if (!rst && debug_wb_rf_we === 1'b1) begin
            if (!first_seen && debug_wb_pc !== `CPU_RESET_PC) begin
                $display("[FAIL] debug_wb_pc: got %h, expected %h on first retire",
                         debug_wb_pc, `CPU_RESET_PC);
                errors++;
            end
            first_seen = 1'b1;
            if (exp_pc.size() == 0) begin
                $display("Write to r%0d at pc %h came after the end of the expected trace",
                         debug_wb_rf_wnum, debug_wb_pc);
                errors++;
            end else begin
                if (debug_wb_pc !== exp_pc[0]) begin
                    $display("[FAIL] debug_wb_pc: got %h, expected %h", debug_wb_pc, exp_pc[0]);
                    errors++;
                end
                if (debug_wb_rf_wnum !== exp_num[0]) begin
                    $display("[FAIL] debug_wb_rf_wnum: got %h, expected %h",
                             debug_wb_rf_wnum, exp_num[0]);
                    errors++;
                end
                if (debug_wb_rf_wdata !== exp_val[0]) begin
                    $display("[FAIL] debug_wb_rf_wdata: got %h, expected %h at pc %h",
                             debug_wb_rf_wdata, exp_val[0], exp_pc[0]);
                    errors++;
                end
                void'(exp_pc.pop_front());
                void'(exp_num.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    task automatic run_test(input int kind, input string name);
        int err0;
        int cycles;
        int limit;
        err0 = errors;
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (2) @(posedge clk);
        build_program(kind);
        run_model();
        repeat (14) begin
            @(negedge clk);
            if (debug_wb_rf_we !== 1'b0 || data_sram_we !== 4'b0) begin
                $display("A write enable was active during reset");
                errors++;
            end
        end
        @(posedge clk);
        #1 rst = 1'b0;
        first_seen = 1'b0;
        limit  = n_words * 8 + 100;
        cycles = 0;
        while (exp_pc.size() != 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_pc.size() != 0) begin
            $display("%0d expected writebacks never appeared", exp_pc.size());
            errors++;
        end
        // Extra writebacks would show up here
        repeat (8) @(negedge clk);
        // Stores that were never loaded back
        foreach (exp_mem[i]) begin
            if (dmem[i] !== exp_mem[i]) begin
                $display("[FAIL] dmem[%0d]: got %h, expected %h", i, dmem[i], exp_mem[i]);
                errors++;
            end
        end
        if (errors == err0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: FAILED with %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        #((NUM_TESTS * PROG_WORDS * 8 + 100) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        first_seen      = 1'b0;
        errors          = 0;
        pass_count      = 0;
        fail_count      = 0;
        run_test(0, "alu_random");
        run_test(1, "forwarding");
        run_test(2, "load_store");
        run_test(3, "branches");
        run_test(4, "link_jumps");
        $display("Tests: %0d ok, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: cpu.f
+incdir+hw
hw/cpu_pkg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/hazard_unit.sv
hw/cpu_top.sv
tests/cpu_tb.sv
